/* include/pwm_array_cfg.svh */
`ifndef PWM_ARRAY_CFG_SVH
`define PWM_ARRAY_CFG_SVH

//////////////////////////////
// Carrier timing
//////////////////////////////
`define PWM_PERIOD        1250        // 50 MHz clock over 40 kHz carrier
`define PWM_COUNT_W       11          // Holds 0 .. PWM_PERIOD-1

//////////////////////////////
// Transducer array
//////////////////////////////
`define PWM_NUM_CHANNELS  8
`define PWM_CHAN_IDX_W    3           // Selects one of PWM_NUM_CHANNELS

//////////////////////////////
// APB bus and register map
//////////////////////////////
`define APB_ADDR_W        8
`define APB_DATA_W        32
`define REG_CTRL_ADDR     8'h00
`define REG_CTRL_EN_BIT   0           // Global output enable
`define REG_CHAN_BASE     8'h04       // Channel c at base + 4*c
`define CHAN_PHASE_LSB    0           // Phase in bits 10:0
`define CHAN_WIDTH_LSB    16          // Width in bits 26:16

`endif

/* source/pwm_array_pkg.sv */
`include "pwm_array_cfg.svh"

package pwm_array_pkg;

   //////////////////////////////
   // Scalar widths
   //////////////////////////////
   typedef logic [`PWM_COUNT_W-1:0] carrier_count_t;  // Position within the period
   typedef logic [`PWM_COUNT_W-1:0] phase_t;          // Delay of a channel's pulse
   typedef logic [`PWM_COUNT_W-1:0] width_t;          // High time of a pulse
   typedef logic [`APB_ADDR_W-1:0]  apb_addr_t;
   typedef logic [`APB_DATA_W-1:0]  apb_data_t;

   //////////////////////////////
   // Channel settings
   //////////////////////////////
   typedef struct packed {
      phase_t phase;
      width_t width;
   } chan_setting_t;

   typedef chan_setting_t [`PWM_NUM_CHANNELS-1:0] chan_setting_array_t;

   //////////////////////////////
   // Pipeline data
   //////////////////////////////
   typedef struct packed {
      logic           run;    // Carrier running
      carrier_count_t count;
   } carrier_t;

   typedef carrier_count_t [`PWM_NUM_CHANNELS-1:0] offset_array_t;

   //////////////////////////////
   // APB request and response
   //////////////////////////////
   typedef struct packed {
      logic      sel;
      logic      enable;
      logic      write;
      apb_addr_t addr;
      apb_data_t wdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t rdata;
      logic      ready;
      logic      slverr;
   } apb_rsp_t;

endpackage

/* source/apb_channel_regs.sv */
`timescale 1ns/10ps
`include "pwm_array_cfg.svh"

module apb_channel_regs (
   input  logic                               CLK,
   input  logic                               rst_n,
   input  pwm_array_pkg::apb_req_t            apb_req,
   output pwm_array_pkg::apb_rsp_t            apb_rsp,
   output logic                               run_enable,
   output pwm_array_pkg::chan_setting_array_t shadow_settings
);

   logic                          access;
   logic                          aligned;
   logic                          ctrl_hit;
   logic                          chan_hit;
   logic                          map_hit;
   logic                          range_bad;
   logic                          wr_ok;
   pwm_array_pkg::apb_addr_t      chan_offs;
   logic [`PWM_CHAN_IDX_W-1:0]    chan_idx;
   pwm_array_pkg::chan_setting_t  wr_setting;
   pwm_array_pkg::apb_data_t      rd_word;

   //////////////////////////////
   // Address decode
   //////////////////////////////
   assign access    = apb_req.sel && apb_req.enable;          // Access phase
   assign aligned   = (apb_req.addr[1:0] == 2'b00);
   assign chan_offs = apb_req.addr - `REG_CHAN_BASE;
   assign chan_idx  = chan_offs[`PWM_CHAN_IDX_W+1:2];

   assign ctrl_hit = aligned && (apb_req.addr == `REG_CTRL_ADDR);
   assign chan_hit = aligned && (apb_req.addr >= `REG_CHAN_BASE)
                     && (chan_offs[`APB_ADDR_W-1:2] < `PWM_NUM_CHANNELS);
   assign map_hit  = ctrl_hit || chan_hit;

   // Phase and width fields of a channel write
   assign wr_setting.phase = apb_req.wdata[`CHAN_PHASE_LSB +: `PWM_COUNT_W];
   assign wr_setting.width = apb_req.wdata[`CHAN_WIDTH_LSB +: `PWM_COUNT_W];
   assign range_bad = (wr_setting.phase >= `PWM_PERIOD)
                      || (wr_setting.width >= `PWM_PERIOD);

   assign wr_ok = access && apb_req.write && map_hit && !(chan_hit && range_bad);

   //////////////////////////////
   // Registers
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         run_enable      <= 1'b0;
         shadow_settings <= '0;
      end else if (wr_ok) begin
         if (ctrl_hit)
            run_enable <= apb_req.wdata[`REG_CTRL_EN_BIT];
         else
            shadow_settings[chan_idx] <= wr_setting;                // Applied at next count 0
      end
   end

   // Read-back mux
   always_comb begin
      rd_word = '0;
      if (ctrl_hit) begin
         rd_word[`REG_CTRL_EN_BIT] = run_enable;
      end else if (chan_hit) begin
         rd_word[`CHAN_PHASE_LSB +: `PWM_COUNT_W] = shadow_settings[chan_idx].phase;
         rd_word[`CHAN_WIDTH_LSB +: `PWM_COUNT_W] = shadow_settings[chan_idx].width;
      end
   end

   //////////////////////////////
   // Response
   //////////////////////////////
   assign apb_rsp.rdata  = (access && !apb_req.write) ? rd_word : '0;
   assign apb_rsp.ready  = 1'b1;                                   // No wait states
   assign apb_rsp.slverr = access
                           && (!map_hit || (apb_req.write && chan_hit && range_bad));

   a_slverr_in_access: assert property (
      @(posedge CLK) disable iff (!rst_n)
      apb_rsp.slverr |-> (apb_req.sel && apb_req.enable)
   );

endmodule

/* source/carrier_counter.sv */
`timescale 1ns/10ps
`include "pwm_array_cfg.svh"

module carrier_counter (
   input  logic                    CLK,
   input  logic                    rst_n,
   input  logic                    run_enable,
   output pwm_array_pkg::carrier_t carrier
);

   pwm_array_pkg::carrier_count_t count_q;

   //////////////////////////////
   // Period counter
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (!run_enable) begin
         count_q <= '0;                                 // Parked at period start
      end else if (count_q == `PWM_PERIOD - 1) begin
         count_q <= '0;                                 // Wrap at period end
      end else begin
         count_q <= count_q + 1'b1;
      end
   end

   // Count 0 after the enable edge is already a live period start
   assign carrier.run   = run_enable;
   assign carrier.count = count_q;

   a_count_range: assert property (
      @(posedge CLK) disable iff (!rst_n)
      count_q < `PWM_PERIOD
   );

endmodule

/* source/phase_offset_stage.sv */
`timescale 1ns/10ps
`include "pwm_array_cfg.svh"

module phase_offset_stage (
   input  logic                                              CLK,
   input  logic                                              rst_n,
   input  pwm_array_pkg::carrier_t                           carrier,
   input  pwm_array_pkg::chan_setting_array_t                shadow_settings,
   output pwm_array_pkg::carrier_t                           carrier_d,
   output pwm_array_pkg::offset_array_t                      offsets,
   output pwm_array_pkg::width_t [`PWM_NUM_CHANNELS-1:0]     active_widths
);

   localparam logic [`PWM_COUNT_W:0] PERIOD_EXT = `PWM_PERIOD;

   pwm_array_pkg::chan_setting_array_t active_settings;
   pwm_array_pkg::chan_setting_array_t use_settings;
   logic                               period_start;

   // (count - phase) mod PERIOD with one conditional add instead of a divider
   function automatic pwm_array_pkg::carrier_count_t wrap_sub(
      input pwm_array_pkg::carrier_count_t count,
      input pwm_array_pkg::phase_t         phase
   );
      logic [`PWM_COUNT_W:0] diff;
      diff = {1'b0, count} - {1'b0, phase};
      if (diff[`PWM_COUNT_W])                   // Borrow folds back into period
         diff = diff + PERIOD_EXT;
      return diff[`PWM_COUNT_W-1:0];
   endfunction

   //////////////////////////////
   // Active settings
   //////////////////////////////
   assign period_start = (carrier.count == '0);
   assign use_settings = period_start ? shadow_settings : active_settings;  // Bypass at count 0

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         active_settings <= '0;
         carrier_d       <= '0;
      end else begin
         if (period_start)
            active_settings <= shadow_settings;         // Only at period boundary
         carrier_d <= carrier;
      end
   end

   //////////////////////////////
   // Per-channel offset
   //////////////////////////////
   always_ff @(posedge CLK) begin
      for (int c = 0; c < `PWM_NUM_CHANNELS; c++) begin
         offsets[c]       <= wrap_sub(carrier.count, use_settings[c].phase);
         active_widths[c] <= use_settings[c].width;
      end
   end

   for (genvar c = 0; c < `PWM_NUM_CHANNELS; c++) begin : g_offset_chk
      a_offset_range: assert property (
         @(posedge CLK) disable iff (!rst_n)
         offsets[c] < `PWM_PERIOD
      );
   end

endmodule

/* source/pulse_output_stage.sv */
`timescale 1ns/10ps
`include "pwm_array_cfg.svh"

module pulse_output_stage (
   input  logic                                          CLK,
   input  logic                                          rst_n,
   input  pwm_array_pkg::carrier_t                       carrier_d,
   input  pwm_array_pkg::offset_array_t                  offsets,
   input  pwm_array_pkg::width_t [`PWM_NUM_CHANNELS-1:0] active_widths,
   output logic [`PWM_NUM_CHANNELS-1:0]                  trans
);

   logic [`PWM_NUM_CHANNELS-1:0] pulse_on;

   //////////////////////////////
   // Width compare
   //////////////////////////////
   always_comb begin
      for (int c = 0; c < `PWM_NUM_CHANNELS; c++) begin
         // Offset runs 0 .. PERIOD-1 from the phase point, so pulses span the wrap
         pulse_on[c] = carrier_d.run && (offsets[c] < active_widths[c]);
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         trans <= '0;
      end else begin
         trans <= pulse_on;                              // To transducers
      end
   end

   a_trans_off_when_stopped: assert property (
      @(posedge CLK) disable iff (!rst_n)
      !carrier_d.run |=> (trans == '0)
   );

endmodule

/* source/pwm_array_top.sv */
`timescale 1ns/10ps
`include "pwm_array_cfg.svh"

module pwm_array_top (
   input  logic                             CLK,
   input  logic                             rst_n,
   input  pwm_array_pkg::apb_req_t          apb_req,
   output pwm_array_pkg::apb_rsp_t          apb_rsp,
   output logic [`PWM_NUM_CHANNELS-1:0]     trans
);

   logic                                          run_enable;
   pwm_array_pkg::chan_setting_array_t            shadow_settings;
   pwm_array_pkg::carrier_t                       carrier;
   pwm_array_pkg::carrier_t                       carrier_d;
   pwm_array_pkg::offset_array_t                  offsets;
   pwm_array_pkg::width_t [`PWM_NUM_CHANNELS-1:0] active_widths;

   //////////////////////////////
   // Host registers
   //////////////////////////////
   apb_channel_regs i_apb_channel_regs (
      .CLK             (CLK),
      .rst_n           (rst_n),
      .apb_req         (apb_req),
      .apb_rsp         (apb_rsp),
      .run_enable      (run_enable),
      .shadow_settings (shadow_settings)
   );

   //////////////////////////////
   // Carrier pipeline
   //////////////////////////////
   carrier_counter i_carrier_counter (          // Stage 1
      .CLK        (CLK),
      .rst_n      (rst_n),
      .run_enable (run_enable),
      .carrier    (carrier)
   );

   phase_offset_stage i_phase_offset_stage (    // Stage 2
      .CLK             (CLK),
      .rst_n           (rst_n),
      .carrier         (carrier),
      .shadow_settings (shadow_settings),
      .carrier_d       (carrier_d),
      .offsets         (offsets),
      .active_widths   (active_widths)
   );

   pulse_output_stage i_pulse_output_stage (    // Stage 3
      .CLK           (CLK),
      .rst_n         (rst_n),
      .carrier_d     (carrier_d),
      .offsets       (offsets),
      .active_widths (active_widths),
      .trans         (trans)
   );

endmodule

/* test/pwm_array_tb.sv */
`timescale 1ns/10ps
`include "pwm_array_cfg.svh"

module pwm_array_tb;

   localparam int RESET_CYCLES   = 5;
   localparam int APB_CMD_CYCLES = 20;                  // Budget per APB command
   localparam int PERIOD         = `PWM_PERIOD;
   localparam int CHAN_BASE      = `REG_CHAN_BASE;

   logic                         CLK;
   logic                         rst_n;
   pwm_array_pkg::apb_req_t      apb_req;
   pwm_array_pkg::apb_rsp_t      apb_rsp;
   logic [`PWM_NUM_CHANNELS-1:0] trans;

   byte         cmd_kind [$];                           // Parsed vectors file
   logic [31:0] cmd_addr [$];
   logic [31:0] cmd_data [$];
   logic [31:0] cmd_err  [$];

   int     budget_cycles = 0;
   integer seed          = 32'ha6f27cfa;

   //////////////////////////////
   // Reference model state
   //////////////////////////////
   logic                         m_run;                 // Enable after the latest edge
   int                           m_count;
   int                           shadow_phase [`PWM_NUM_CHANNELS];
   int                           shadow_width [`PWM_NUM_CHANNELS];
   int                           active_phase [`PWM_NUM_CHANNELS];
   int                           active_width [`PWM_NUM_CHANNELS];
   logic [`PWM_NUM_CHANNELS-1:0] m_pipe;                // Levels one stage before trans
   logic [`PWM_NUM_CHANNELS-1:0] m_trans;

   initial CLK = 1'b0;
   always #4 CLK = ~CLK;

   pwm_array_top i_pwm_array_top (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .trans   (trans)
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // High while (count - phase) mod PERIOD is below the width
   function automatic logic pulse_level(input int count, input int phase, input int width);
      return ((count - phase + PERIOD) % PERIOD) < width;
   endfunction

   function automatic logic write_accepted(input logic [7:0] addr, input logic [31:0] data);
      int a;
      a = int'(addr);
      if (addr[1:0] != 2'b00)
         return 1'b0;                                   // Misaligned
      if (addr == `REG_CTRL_ADDR)
         return 1'b1;
      if (a < CHAN_BASE || a >= CHAN_BASE + 4 * `PWM_NUM_CHANNELS)
         return 1'b0;                                   // Unmapped
      return (int'(data[`CHAN_PHASE_LSB +: `PWM_COUNT_W]) < PERIOD)
             && (int'(data[`CHAN_WIDTH_LSB +: `PWM_COUNT_W]) < PERIOD);
   endfunction

   //////////////////////////////
   // Model and output check
   //////////////////////////////
   always @(posedge CLK) begin
      logic [`PWM_NUM_CHANNELS-1:0] next_pipe;
      int                           chan;
      if (!rst_n) begin
         m_run   = 1'b0;
         m_count = 0;
         m_pipe  = '0;
         m_trans = '0;
         for (int c = 0; c < `PWM_NUM_CHANNELS; c++) begin
            shadow_phase[c] = 0;
            shadow_width[c] = 0;
            active_phase[c] = 0;
            active_width[c] = 0;
         end
      end else begin
         assert (trans === m_trans) else
            stop_on_error($sformatf("MISMATCH trans expected %h actual %h", m_trans, trans));
         if (m_count == 0) begin
            active_phase = shadow_phase;                // New set at the period boundary
            active_width = shadow_width;
         end
         for (int c = 0; c < `PWM_NUM_CHANNELS; c++)
            next_pipe[c] = m_run && pulse_level(m_count, active_phase[c], active_width[c]);
         m_trans = m_pipe;
         m_pipe  = next_pipe;
         m_count = m_run ? (m_count + 1) % PERIOD : 0;
         // APB write completing on this edge
         if (apb_req.sel && apb_req.enable && apb_req.write
             && write_accepted(apb_req.addr, apb_req.wdata)) begin
            if (apb_req.addr == `REG_CTRL_ADDR) begin
               m_run = apb_req.wdata[`REG_CTRL_EN_BIT];
            end else begin
               chan = (int'(apb_req.addr) - CHAN_BASE) / 4;
               shadow_phase[chan] = int'(apb_req.wdata[`CHAN_PHASE_LSB +: `PWM_COUNT_W]);
               shadow_width[chan] = int'(apb_req.wdata[`CHAN_WIDTH_LSB +: `PWM_COUNT_W]);
            end
         end
      end
   end

   task automatic apb_transfer(input logic is_write, input logic [31:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata,
                               output logic slverr);
      @(posedge CLK);
      apb_req.sel    <= 1'b1;                           // Setup phase
      apb_req.enable <= 1'b0;
      apb_req.write  <= is_write;
      apb_req.addr   <= addr[`APB_ADDR_W-1:0];
      apb_req.wdata  <= is_write ? data : '0;
      @(posedge CLK);
      apb_req.enable <= 1'b1;                           // Access phase
      @(negedge CLK);
      assert (apb_rsp.ready === 1'b1) else
         stop_on_error($sformatf("MISMATCH ready at addr %h expected %h actual %h",
                                 addr, 1'b1, apb_rsp.ready));
      rdata  = apb_rsp.rdata;
      slverr = apb_rsp.slverr;
      @(posedge CLK);                                   // Completing edge
      apb_req <= '0;
   endtask

   initial begin
      wait (budget_cycles > 0);
      repeat (budget_cycles) @(posedge CLK);
      stop_on_error($sformatf("Timeout, the run did not end within %0d clock cycles",
                              budget_cycles));
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial begin
      int          fd;
      int          n;
      int          idle;
      byte         kind;
      string       line;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;
      logic [31:0] rdata;
      logic        slverr;
      apb_req = '0;
      rst_n   = 1'b0;
      fd = $fopen("test/pwm_array_vectors.txt", "r");
      assert (fd != 0) else
         stop_on_error("Could not open test/pwm_array_vectors.txt");
      while (!$feof(fd)) begin
         n = $fscanf(fd, " %c", kind);
         if (n == 1) begin
            case (kind)
               "#": n = $fgets(line, fd);               // Comment line
               "W", "R": begin
                  n = $fscanf(fd, " %h %h %h", a, d, e);
                  assert (n == 3) else
                     stop_on_error("An APB command in the vectors file is incomplete");
                  cmd_kind.push_back(kind);
                  cmd_addr.push_back(a);
                  cmd_data.push_back(d);
                  cmd_err.push_back(e);
                  budget_cycles += APB_CMD_CYCLES;
               end
               "C": begin
                  n = $fscanf(fd, " %d", d);
                  assert (n == 1) else
                     stop_on_error("A run command in the vectors file has no cycle count");
                  cmd_kind.push_back(kind);
                  cmd_addr.push_back('0);
                  cmd_data.push_back(d);
                  cmd_err.push_back('0);
                  budget_cycles += int'(d);
               end
               default: stop_on_error($sformatf("Unknown command %c in the vectors file", kind));
            endcase
         end
      end
      $fclose(fd);
      budget_cycles += RESET_CYCLES + APB_CMD_CYCLES;

      repeat (RESET_CYCLES) @(posedge CLK);
      rst_n <= 1'b1;

      foreach (cmd_kind[i]) begin
         if (cmd_kind[i] == "C") begin
            repeat (cmd_data[i]) @(posedge CLK);        // Outputs checked every edge
         end else begin
            apb_transfer(cmd_kind[i] == "W", cmd_addr[i], cmd_data[i], rdata, slverr);
            assert (slverr === cmd_err[i][0]) else
               stop_on_error($sformatf("MISMATCH slverr at addr %h expected %h actual %h",
                                       cmd_addr[i], cmd_err[i][0], slverr));
            if (cmd_kind[i] == "R") begin
               assert (rdata === cmd_data[i]) else
                  stop_on_error($sformatf("MISMATCH rdata at addr %h expected %h actual %h",
                                          cmd_addr[i], cmd_data[i], rdata));
            end
            idle = $random(seed) & 32'h3;
            repeat (idle) @(posedge CLK);
         end
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* test/pwm_array_vectors.txt */
# W addr data slverr : APB write, R addr expected_rdata slverr : APB read (hex)
# C cycles : run with output checks for that many clock cycles (decimal)
C 200
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
R 1C 00000000 0
R 20 00000000 0
W 04 02710000 0
W 08 02710076 0
W 0C 02710131 0
W 10 02710200 0
W 14 027102F8 0
W 18 027103D5 0
W 1C 0190046A 0
W 20 012C04E1 0
R 1C 0190046A 0
W 00 00000001 0
C 4000
W 0C 00500100 0
R 0C 00500100 0
C 2600
W 24 02710000 1
W 06 02710000 1
W 08 027104E2 1
W 08 04E20076 1
R 08 02710076 0
R 24 00000000 1
R 05 00000000 1
R 00 00000001 0
W 14 00000123 0
W 18 04E102A0 0
C 2600
W 00 00000000 0
C 50
R 00 00000000 0
W 00 00000001 0
C 1300

/* build.f */
+incdir+include
source/pwm_array_pkg.sv
source/apb_channel_regs.sv
source/carrier_counter.sv
source/phase_offset_stage.sv
source/pulse_output_stage.sv
source/pwm_array_top.sv
test/pwm_array_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the PWM array testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f build.f --top-module pwm_array_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vpwm_array_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

echo "Simulation ended with status 0"
exit 0
